/* include/cheri_fetch_defines.svh */
// build-time constants for the fetch stage
// prefetch FIFO depth, bus request limit, debug entry addresses, boot offset

`ifndef CHERI_FETCH_DEFINES_SVH
`define CHERI_FETCH_DEFINES_SVH

////////////////////
// prefetch sizing
////////////////////

// fetched words held between the bus and the IF-ID register
`define FETCH_FIFO_DEPTH 3

// granted requests still waiting for rvalid
`define FETCH_MAX_OUTSTANDING 2

////////////////////
// fixed addresses
////////////////////

// debug module halt entry
`define DM_HALT_ADDR 32'h1A11_0800

// debug module exception entry
`define DM_EXC_ADDR 32'h1A11_0808

// low byte placed under boot_addr_i[31:8]
`define BOOT_OFFSET 8'h80

`endif

/* verilog/cheri_fetch_pkg.sv */
// shared types for the fetch stage
// pc source enums, redirect command, capability, bus and pipeline structs

`default_nettype none

package cheri_fetch_pkg;

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // kind of trap target
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // redirect command from the controller
  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
    logic [4:0]  irq_id;
  } pc_ctrl_t;

  // candidate redirect addresses
  typedef struct packed {
    logic [31:0] branch_target;
    logic [31:0] csr_mepc;
    logic [31:0] csr_depc;
    logic [31:0] csr_mtvec;
  } pc_targets_t;

  // program-counter capability, decoded bounds
  typedef struct packed {
    logic [31:0] base32;
    logic [32:0] top33;
    logic        perm_ex;
    logic        valid;
    logic [2:0]  otype;
  } pcc_cap_t;

  // instruction bus, master side
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } instr_bus_req_t;

  // instruction bus, slave side
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } instr_bus_rsp_t;

  // one prefetch FIFO word
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_entry_t;

  // IF-ID register contents
  typedef struct packed {
    logic [31:0] rdata;
    logic [31:0] pc;
    logic        fetch_err;
  } id_instr_t;

endpackage

`default_nettype wire

/* verilog/fetch_pc_mux.sv */
// next fetch address selection
// trap vector forming (direct and vectored), boot address, mtvec init pulse

`default_nettype none

`include "cheri_fetch_defines.svh"

module fetch_pc_mux import cheri_fetch_pkg::*; (
  input  pc_ctrl_t    ctrl_i,
  input  pc_targets_t targets_i,
  input  logic [31:0] boot_addr_i,
  output logic [31:0] fetch_addr_o,
  output logic        mtvec_init_o
);

  logic [31:0] exc_pc;
  logic [31:0] mtvec;
  logic [31:0] boot_pc;

  assign mtvec   = targets_i.csr_mtvec;
  // boot entry sits at a fixed offset inside the 256 byte boot page
  assign boot_pc = {boot_addr_i[31:8], `BOOT_OFFSET};

  ////////////////////
  // trap vector
  ////////////////////

  // mtvec bit 0 selects vectored mode, base then 256 byte aligned
  always_comb begin
    unique case (ctrl_i.exc_pc_mux)
      EXC_PC_EXC: begin
        exc_pc = mtvec[0] ? {mtvec[31:8], 8'h00} : {mtvec[31:2], 2'b00};
      end
      EXC_PC_IRQ: begin
        // one word slot per interrupt line
        exc_pc = mtvec[0] ? {mtvec[31:8], 1'b0, ctrl_i.irq_id, 2'b00}
                          : {mtvec[31:2], 2'b00};
      end
      EXC_PC_DBD: begin
        exc_pc = `DM_HALT_ADDR;
      end
      EXC_PC_DBG_EXC: begin
        exc_pc = `DM_EXC_ADDR;
      end
      default: begin
        exc_pc = {mtvec[31:8], 8'h00};
      end
    endcase
  end

  ////////////////////
  // fetch address
  ////////////////////

  always_comb begin
    unique case (ctrl_i.pc_mux)
      PC_BOOT: fetch_addr_o = boot_pc;
      PC_JUMP: fetch_addr_o = targets_i.branch_target;
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap
      PC_ERET: fetch_addr_o = targets_i.csr_mepc;
      // return from debug mode
      PC_DRET: fetch_addr_o = targets_i.csr_depc;
      default: fetch_addr_o = boot_pc;
    endcase
  end

  // CSR file loads its reset mtvec on the boot redirect
  assign mtvec_init_o = ctrl_i.pc_set & (ctrl_i.pc_mux == PC_BOOT);

endmodule

`default_nettype wire

/* verilog/prefetch_fifo.sv */
// prefetch buffer on the req/gnt/rvalid instruction bus
// credit-limited request issue, outstanding and discard counters,
// response FIFO, flush on redirect

`default_nettype none

`include "cheri_fetch_defines.svh"

module prefetch_fifo import cheri_fetch_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           branch_i,
  input  logic [31:0]    branch_addr_i,
  input  logic           ready_i,
  output logic           valid_o,
  output fetch_entry_t   entry_o,
  output instr_bus_req_t bus_req_o,
  input  instr_bus_rsp_t bus_rsp_i,
  output logic           busy_o
);

  localparam int unsigned Depth  = `FETCH_FIFO_DEPTH;
  localparam int unsigned MaxOut = `FETCH_MAX_OUTSTANDING;
  localparam int unsigned PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW   = $clog2(Depth + 1);
  localparam int unsigned OutW   = $clog2(MaxOut + 1);

  fetch_entry_t    mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q, count_d, free_slots;
  logic [OutW-1:0] out_cnt_q, out_cnt_d;
  logic [OutW-1:0] discard_q, discard_d;
  logic            addr_valid_q;
  logic            hold_q, hold_stale_q;
  logic [31:0]     fetch_addr_q, hold_addr_q, rsp_addr_q;
  logic [31:0]     target_addr;
  logic            credit_ok, issue, grant;
  logic            drop, push, pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    ptr_inc = (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // only whole words are fetched
  assign target_addr = {branch_addr_i[31:2], 2'b00};

  ////////////////////
  // request side
  ////////////////////

  // a new request needs a free slot beyond every answer still due
  assign free_slots = CntW'(Depth) - count_q;
  assign credit_ok  = (32'(free_slots) > 32'(out_cnt_q)) && (32'(out_cnt_q) < MaxOut);
  assign issue      = req_i & addr_valid_q & ~branch_i & credit_ok;

  // an ungranted request is held with its address until gnt
  assign bus_req_o.req  = hold_q | issue;
  assign bus_req_o.addr = hold_q ? hold_addr_q : fetch_addr_q;
  assign grant          = bus_req_o.req & bus_rsp_i.gnt;

  ////////////////////
  // response side
  ////////////////////

  // answers to requests from before a redirect are thrown away
  assign drop = bus_rsp_i.rvalid & (discard_q != '0);
  assign push = bus_rsp_i.rvalid & (discard_q == '0) & ~branch_i;
  assign pop  = valid_o & ready_i;

  assign out_cnt_d = out_cnt_q + OutW'(grant) - OutW'(bus_rsp_i.rvalid);

  always_comb begin
    if (branch_i) begin
      // everything still outstanding after this edge belongs to the old stream
      discard_d = out_cnt_d;
    end else begin
      discard_d = discard_q - OutW'(drop) + OutW'(grant & hold_stale_q);
    end
  end

  always_comb begin
    if (branch_i) begin
      count_d = '0;
    end else begin
      count_d = count_q + CntW'(push) - CntW'(pop);
    end
  end

  // control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_valid_q <= 1'b0;
      hold_q       <= 1'b0;
      hold_stale_q <= 1'b0;
      out_cnt_q    <= '0;
      discard_q    <= '0;
      count_q      <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
    end else begin
      addr_valid_q <= addr_valid_q | branch_i;
      hold_q       <= bus_req_o.req & ~bus_rsp_i.gnt;
      // a held request overtaken by a redirect is answered but not kept
      hold_stale_q <= bus_req_o.req & ~bus_rsp_i.gnt & (hold_stale_q | branch_i);
      out_cnt_q    <= out_cnt_d;
      discard_q    <= discard_d;
      count_q      <= count_d;
      if (branch_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
      end
    end
  end

  // addresses and data
  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      fetch_addr_q <= target_addr;
      rsp_addr_q   <= target_addr;
    end else begin
      if (grant & ~hold_stale_q) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      // kept answers are sequential from the redirect target
      if (push) begin
        rsp_addr_q <= rsp_addr_q + 32'd4;
      end
    end
    if (bus_req_o.req & ~hold_q) begin
      hold_addr_q <= fetch_addr_q;
    end
    if (push) begin
      mem_q[wr_ptr_q] <= '{rdata: bus_rsp_i.rdata, addr: rsp_addr_q, err: bus_rsp_i.err};
    end
  end

  assign valid_o = (count_q != '0);
  assign entry_o = mem_q[rd_ptr_q];
  assign busy_o  = (out_cnt_q != '0) | bus_req_o.req;

endmodule

`default_nettype wire

/* verilog/pcc_fetch_check.sv */
// fetch access check against the program-counter capability
// bounds, execute permission, tag and seal, merged with bus and PMP errors

`default_nettype none

module pcc_fetch_check import cheri_fetch_pkg::*; (
  input  logic         cheri_pmode_i,
  input  logic         debug_mode_i,
  input  pcc_cap_t     pcc_cap_i,
  input  logic         valid_i,
  input  fetch_entry_t entry_i,
  input  logic         pmp_err_i,
  output logic         fetch_err_o
);

  logic [32:0] instr_end;
  logic        below_base;
  logic        above_top;
  logic        cap_bad;
  logic        check_en;
  logic        cheri_vio;

  // end of the word, one bit wider so the top of memory compares right
  assign instr_end  = {1'b0, entry_i.addr} + 33'd4;
  assign below_base = (entry_i.addr < pcc_cap_i.base32);
  assign above_top  = (instr_end > pcc_cap_i.top33);

  // capability itself unusable for fetch
  assign cap_bad = ~pcc_cap_i.perm_ex | ~pcc_cap_i.valid | (pcc_cap_i.otype != 3'd0);

  // no check in legacy mode or debug mode
  // words already failing on the bus report that error instead
  assign check_en  = cheri_pmode_i & ~debug_mode_i & valid_i & ~entry_i.err;
  assign cheri_vio = check_en & (below_base | above_top | cap_bad);

  assign fetch_err_o = cheri_vio | entry_i.err | pmp_err_i;

endmodule

`default_nettype wire

/* verilog/if_id_stage_reg.sv */
// IF-ID pipeline register
// valid and new flags, instruction register, sequential PC alarm

`default_nettype none

module if_id_stage_reg import cheri_fetch_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         fetch_valid_i,
  input  fetch_entry_t entry_i,
  input  logic         fetch_err_i,
  input  logic         id_in_ready_i,
  input  logic         branch_i,
  input  logic         valid_clear_i,
  output logic         instr_valid_id_o,
  output logic         instr_new_id_o,
  output id_instr_t    id_instr_o,
  output logic         pc_mismatch_alert_o
);

  logic        accept;
  logic        valid_d, valid_q;
  logic        new_q;
  logic        seq_d, seq_q;
  logic [31:0] pc_incr;

  // a word moves into ID when offered and ID can take it
  assign accept = fetch_valid_i & id_in_ready_i;

  ////////////////////
  // flags
  ////////////////////

  // a word taken with a redirect is squashed
  // valid otherwise holds until the core retires or flushes it
  assign valid_d = (accept & ~branch_i) | (valid_q & ~valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
      seq_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= accept;
      seq_q   <= seq_d;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // instruction register, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_instr_o <= '{rdata: entry_i.rdata, pc: entry_i.addr, fetch_err: fetch_err_i};
    end
  end

  ////////////////////
  // pc hardening
  ////////////////////

  // stream counts as sequential after a load with no redirect or error since
  assign seq_d = (seq_q | accept) & ~branch_i & ~(fetch_valid_i & fetch_err_i);

  assign pc_incr = id_instr_o.pc + 32'd4;

  // next word offered must follow the one held in ID
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (entry_i.addr != pc_incr);

endmodule

`default_nettype wire

/* verilog/cheri_fetch_top.sv */
// fetch stage top level
// pc mux, prefetch buffer, capability check and IF-ID register

`default_nettype none

module cheri_fetch_top import cheri_fetch_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic [31:0]    boot_addr_i,
  input  logic           cheri_pmode_i,
  input  logic           debug_mode_i,
  input  pcc_cap_t       pcc_cap_i,
  input  logic           pmp_err_if_i,
  input  pc_ctrl_t       pc_ctrl_i,
  input  pc_targets_t    pc_targets_i,
  input  logic           id_in_ready_i,
  input  logic           instr_valid_clear_i,
  output instr_bus_req_t instr_bus_req_o,
  input  instr_bus_rsp_t instr_bus_rsp_i,
  output logic           instr_valid_id_o,
  output logic           instr_new_id_o,
  output id_instr_t      id_instr_o,
  output logic [31:0]    pc_if_o,
  output logic           csr_mtvec_init_o,
  output logic           if_busy_o,
  output logic           pc_mismatch_alert_o
);

  logic [31:0]  fetch_addr_n;
  logic         fetch_valid;
  fetch_entry_t fetch_entry;
  logic         fetch_err;

  // address of the word now offered to ID
  assign pc_if_o = fetch_entry.addr;

  fetch_pc_mux u_pc_mux (
    .ctrl_i       (pc_ctrl_i),
    .targets_i    (pc_targets_i),
    .boot_addr_i  (boot_addr_i),
    .fetch_addr_o (fetch_addr_n),
    .mtvec_init_o (csr_mtvec_init_o)
  );

  // a redirect flushes the buffer and restarts the bus stream
  prefetch_fifo u_prefetch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (pc_ctrl_i.pc_set),
    .branch_addr_i (fetch_addr_n),
    .ready_i       (id_in_ready_i),
    .valid_o       (fetch_valid),
    .entry_o       (fetch_entry),
    .bus_req_o     (instr_bus_req_o),
    .bus_rsp_i     (instr_bus_rsp_i),
    .busy_o        (if_busy_o)
  );

  pcc_fetch_check u_pcc_check (
    .cheri_pmode_i (cheri_pmode_i),
    .debug_mode_i  (debug_mode_i),
    .pcc_cap_i     (pcc_cap_i),
    .valid_i       (fetch_valid),
    .entry_i       (fetch_entry),
    .pmp_err_i     (pmp_err_if_i),
    .fetch_err_o   (fetch_err)
  );

  if_id_stage_reg u_if_id (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .entry_i             (fetch_entry),
    .fetch_err_i         (fetch_err),
    .id_in_ready_i       (id_in_ready_i),
    .branch_i            (pc_ctrl_i.pc_set),
    .valid_clear_i       (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_instr_o          (id_instr_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

`default_nettype wire

/* sim/cheri_fetch_properties.sv */
// bus and pipeline flag assertions for the fetch stage
// bound into cheri_fetch_top

`default_nettype none

`include "cheri_fetch_defines.svh"

module cheri_fetch_properties import cheri_fetch_pkg::*; (
  input logic           clk_i,
  input logic           rst_ni,
  input pc_ctrl_t       pc_ctrl_i,
  input instr_bus_req_t instr_bus_req_o,
  input instr_bus_rsp_t instr_bus_rsp_i,
  input logic           instr_valid_id_o,
  input logic           instr_new_id_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int out_cnt;

  // granted requests still waiting for rvalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_cnt <= 0;
    end else begin
      out_cnt <= out_cnt + int'(instr_bus_req_o.req & instr_bus_rsp_i.gnt)
                 - int'(instr_bus_rsp_i.rvalid);
    end
  end

  default disable iff (!rst_ni);

  // held request keeps its address until gnt
  addr_stable: assert property (@(posedge clk_i)
    instr_bus_req_o.req && !instr_bus_rsp_i.gnt |=>
      instr_bus_req_o.req && $stable(instr_bus_req_o.addr))
    else $error("request address changed before grant");

  word_aligned: assert property (@(posedge clk_i)
    instr_bus_req_o.req |-> instr_bus_req_o.addr[1:0] == 2'b00)
    else $error("request address not word aligned");

  // squashed words arrive new but not valid
  new_is_valid: assert property (@(posedge clk_i)
    instr_new_id_o && !$past(pc_ctrl_i.pc_set) |-> instr_valid_id_o)
    else $error("new instruction in ID without valid");

  outstanding_limit: assert property (@(posedge clk_i)
    out_cnt <= `FETCH_MAX_OUTSTANDING)
    else $error("too many outstanding requests");

endmodule

bind cheri_fetch_top cheri_fetch_properties props_inst (.*);

`default_nettype wire

/* sim/cheri_fetch_tb.sv */
// testbench for the fetch stage
// clock, reset, instruction bus responder, directed test tasks

`default_nettype none

`include "cheri_fetch_defines.svh"

module cheri_fetch_tb import cheri_fetch_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic clk_i, rst_ni, req_i, cheri_pmode_i, debug_mode_i, pmp_err_if_i;
  logic id_in_ready_i, instr_valid_clear_i;
  logic [31:0] boot_addr_i, pc_if_o;
  pcc_cap_t pcc_cap_i;
  pc_ctrl_t pc_ctrl_i;
  pc_targets_t pc_targets_i;
  instr_bus_req_t bus_req;
  instr_bus_rsp_t bus_rsp;
  logic instr_valid_id_o, instr_new_id_o, csr_mtvec_init_o, if_busy_o, pc_mismatch_alert_o;
  id_instr_t id_instr_o;

  int errors, checks, tests, cycle;
  logic [31:0] bus_rng, stim_rng;
  logic [31:0] pend_addr[$];
  int pend_due[$];

  localparam logic [31:0] SEED = 32'h6988_d8a8;
  localparam pcc_cap_t FULL_CAP = '{base32: 32'h0, top33: 33'h1_0000_0000,
                                    perm_ex: 1'b1, valid: 1'b1, otype: 3'd0};

  cheri_fetch_top cheri_fetch_top_inst (
    .clk_i, .rst_ni, .req_i, .boot_addr_i, .cheri_pmode_i, .debug_mode_i, .pcc_cap_i,
    .pmp_err_if_i, .pc_ctrl_i, .pc_targets_i, .id_in_ready_i, .instr_valid_clear_i,
    .instr_bus_req_o(bus_req), .instr_bus_rsp_i(bus_rsp), .instr_valid_id_o,
    .instr_new_id_o, .id_instr_o, .pc_if_o, .csr_mtvec_init_o, .if_busy_o,
    .pc_mismatch_alert_o
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // memory model and the error window
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    return a ^ 32'h5A5A_0000;
  endfunction

  function automatic logic in_err_window(input logic [31:0] a);
    return (a >= 32'h0000_8000) && (a < 32'h0000_8010);
  endfunction

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle <= cycle + 1;

  ////////////////////
  // bus responder
  ////////////////////

  // random grant, in-order answers after a random latency
  always @(posedge clk_i or negedge rst_ni) begin : responder
    logic [31:0] a;
    if (!rst_ni) begin
      bus_rsp <= '0;
      bus_rng <= SEED;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      bus_rng <= xorshift(bus_rng);
      if (bus_req.req && bus_rsp.gnt) begin
        pend_addr.push_back(bus_req.addr);
        pend_due.push_back(cycle + 1 + int'(bus_rng[5:4]));
      end
      bus_rsp.gnt <= bus_rng[0] | bus_rng[1];
      if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
        a = pend_addr.pop_front();
        void'(pend_due.pop_front());
        bus_rsp.rvalid <= 1'b1;
        bus_rsp.rdata  <= mem_word(a);
        bus_rsp.err    <= in_err_window(a);
      end else begin
        bus_rsp.rvalid <= 1'b0;
      end
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  // next valid word to reach ID
  task automatic wait_new(input string name, output logic ok);
    ok = 1'b0;
    for (int i = 0; i < 200 && !ok; i++) begin
      @(posedge clk_i);
      ok = instr_new_id_o && instr_valid_id_o;
    end
    if (!ok) begin
      errors++;
      $display("%s: no instruction reached ID before the timeout", name);
    end
  endtask

  // buffer full and no request left, reached only while ID stalls
  task automatic wait_idle(input string name, output logic ok);
    ok = 1'b0;
    for (int i = 0; i < 200 && !ok; i++) begin
      @(posedge clk_i);
      ok = !if_busy_o;
    end
    if (!ok) begin
      errors++;
      $display("%s: fetch stayed busy until the timeout", name);
    end
  endtask

  // one cycle redirect, ID held off so nothing is squashed into it
  task automatic redirect(input pc_sel_e mux, input exc_pc_sel_e exc, input logic [4:0] irq,
                          output logic init);
    @(posedge clk_i);
    pc_ctrl_i     <= '{pc_set: 1'b1, pc_mux: mux, exc_pc_mux: exc, irq_id: irq};
    id_in_ready_i <= 1'b0;
    @(posedge clk_i);
    init = csr_mtvec_init_o;
    pc_ctrl_i     <= '0;
    id_in_ready_i <= 1'b1;
  endtask

  task automatic expect_first(input string name, input logic [31:0] exp_pc);
    logic ok;
    wait_new(name, ok);
    if (ok) begin
      check_val({name, " pc"}, exp_pc, id_instr_o.pc);
      check_val({name, " data"}, mem_word(exp_pc), id_instr_o.rdata);
    end
  endtask

  task automatic jump_to(input string name, input logic [31:0] target);
    logic init;
    @(posedge clk_i);
    pc_targets_i.branch_target <= target;
    redirect(PC_JUMP, EXC_PC_EXC, 5'd0, init);
    expect_first(name, target);
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    if (errors == err_before) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - err_before);
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic boot_entry();
    int e;
    logic init;
    e = errors;
    redirect(PC_BOOT, EXC_PC_EXC, 5'd0, init);
    check_val("boot mtvec init", 32'd1, 32'(init));
    expect_first("boot", 32'h0000_1280);
    report("boot", e);
  endtask

  task automatic backpressure_stream();
    int e, n;
    logic [31:0] exp_pc;
    e = errors;
    n = 0;
    // boot word at 0x1280 is already in ID
    exp_pc = 32'h0000_1284;
    for (int i = 0; i < 2000 && n < 20; i++) begin
      @(posedge clk_i);
      stim_rng = xorshift(stim_rng);
      id_in_ready_i <= stim_rng[0];
      if (pc_mismatch_alert_o) begin
        errors++;
        $display("stream: pc mismatch alert raised");
      end
      if (instr_new_id_o) begin
        check_val("stream pc", exp_pc, id_instr_o.pc);
        check_val("stream data", mem_word(exp_pc), id_instr_o.rdata);
        exp_pc = exp_pc + 32'd4;
        n++;
      end
    end
    if (n < 20) begin
      errors++;
      $display("stream: only %0d instructions arrived before the timeout", n);
    end
    id_in_ready_i <= 1'b1;
    report("stream", e);
  endtask

  task automatic trap_case(input string name, input logic [31:0] mtvec,
                           input exc_pc_sel_e exc, input logic [31:0] exp_pc);
    logic init;
    @(posedge clk_i);
    pc_targets_i.csr_mtvec <= mtvec;
    redirect(PC_EXC, exc, 5'd5, init);
    expect_first(name, exp_pc);
  endtask

  task automatic redirect_vectors();
    int e;
    logic init;
    e = errors;
    jump_to("jump", 32'h0000_2000);
    redirect(PC_ERET, EXC_PC_EXC, 5'd0, init);
    expect_first("eret", 32'h0000_3000);
    redirect(PC_DRET, EXC_PC_EXC, 5'd0, init);
    expect_first("dret", 32'h0000_4000);
    trap_case("exc direct", 32'h0000_5124, EXC_PC_EXC, 32'h0000_5124);
    trap_case("irq direct", 32'h0000_5124, EXC_PC_IRQ, 32'h0000_5124);
    trap_case("exc vectored", 32'h0000_5001, EXC_PC_EXC, 32'h0000_5000);
    trap_case("irq vectored", 32'h0000_5001, EXC_PC_IRQ, 32'h0000_5014);
    trap_case("debug halt", 32'h0000_5001, EXC_PC_DBD, `DM_HALT_ADDR);
    trap_case("debug exc", 32'h0000_5001, EXC_PC_DBG_EXC, `DM_EXC_ADDR);
    report("redirects", e);
  endtask

  task automatic squash_and_hold();
    int e;
    logic ok;
    e = errors;
    // stall ID until the buffer is full and the bus is quiet
    id_in_ready_i <= 1'b0;
    wait_idle("squash", ok);
    // acceptance in the same cycle as the redirect
    pc_ctrl_i     <= '{pc_set: 1'b1, pc_mux: PC_JUMP, exc_pc_mux: EXC_PC_EXC, irq_id: 5'd0};
    id_in_ready_i <= 1'b1;
    @(posedge clk_i);
    pc_ctrl_i     <= '0;
    id_in_ready_i <= 1'b0;
    @(posedge clk_i);
    check_val("squash new", 32'd1, 32'(instr_new_id_o));
    check_val("squash valid", 32'd0, 32'(instr_valid_id_o));
    // new stream from branch_target waits in the buffer while ID stalls
    wait_idle("refill", ok);
    check_val("refill valid", 32'd0, 32'(instr_valid_id_o));
    check_val("refill pc_if", 32'h0000_2000, pc_if_o);
    // let one word in, then hold it while ID stalls
    instr_valid_clear_i <= 1'b0;
    id_in_ready_i       <= 1'b1;
    @(posedge clk_i);
    id_in_ready_i <= 1'b0;
    expect_first("hold", 32'h0000_2000);
    check_val("hold pc_if", 32'h0000_2004, pc_if_o);
    repeat (5) begin
      @(posedge clk_i);
      check_val("hold valid", 32'd1, 32'(instr_valid_id_o));
      check_val("hold new", 32'd0, 32'(instr_new_id_o));
    end
    instr_valid_clear_i <= 1'b1;
    @(posedge clk_i);
    @(posedge clk_i);
    check_val("cleared valid", 32'd0, 32'(instr_valid_id_o));
    id_in_ready_i <= 1'b1;
    report("squash", e);
  endtask

  // strict mode is capability mode outside debug, the others only see bus and PMP errors
  task automatic err_case(input string name, input logic [31:0] addr, input logic pmp,
                          input pcc_cap_t cap, input logic exp_strict, input logic exp_relaxed);
    logic ok;
    for (int m = 0; m < 3; m++) begin
      @(posedge clk_i);
      cheri_pmode_i <= (m != 2);
      debug_mode_i  <= (m == 1);
      pmp_err_if_i  <= pmp;
      pcc_cap_i     <= cap;
      jump_to(name, addr);
      check_val({name, " fetch_err"}, 32'((m == 0) ? exp_strict : exp_relaxed),
                32'(id_instr_o.fetch_err));
    end
    pmp_err_if_i  <= 1'b0;
    pcc_cap_i     <= FULL_CAP;
    cheri_pmode_i <= 1'b0;
    debug_mode_i  <= 1'b0;
  endtask

  task automatic fetch_errors();
    int e;
    pcc_cap_t cap;
    e = errors;
    cap = '{base32: 32'h0000_1000, top33: 33'h0_0001_0000, perm_ex: 1'b1,
            valid: 1'b1, otype: 3'd0};
    err_case("in bounds", 32'h0000_2000, 1'b0, cap, 1'b0, 1'b0);
    err_case("bus window", 32'h0000_8000, 1'b0, cap, 1'b1, 1'b1);
    err_case("pmp", 32'h0000_2000, 1'b1, cap, 1'b1, 1'b1);
    err_case("below base", 32'h0000_0800, 1'b0, cap, 1'b1, 1'b0);
    err_case("above top", 32'h0001_0000, 1'b0, cap, 1'b1, 1'b0);
    cap.perm_ex = 1'b0;
    err_case("no execute", 32'h0000_2000, 1'b0, cap, 1'b1, 1'b0);
    report("fetch errors", e);
  endtask

  // watchdog so the run always ends
  initial begin
    #2_000_000;
    $display("simulation did not finish in time");
    $display("Regression failed");
    $finish;
  end

  initial begin
    errors = 0;
    checks = 0;
    tests = 0;
    cycle = 0;
    stim_rng = xorshift(SEED);
    rst_ni = 1'b0;
    req_i = 1'b0;
    boot_addr_i = 32'h0000_1234;
    cheri_pmode_i = 1'b0;
    debug_mode_i = 1'b0;
    pmp_err_if_i = 1'b0;
    pcc_cap_i = FULL_CAP;
    pc_ctrl_i = '0;
    pc_targets_i = '{branch_target: 32'h0, csr_mepc: 32'h0000_3000,
                     csr_depc: 32'h0000_4000, csr_mtvec: 32'h0000_5000};
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b1;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    req_i  <= 1'b1;
    boot_entry();
    backpressure_stream();
    redirect_vectors();
    squash_and_hold();
    fetch_errors();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cheri_fetch.f */
+incdir+include
verilog/cheri_fetch_pkg.sv
verilog/fetch_pc_mux.sv
verilog/prefetch_fifo.sv
verilog/pcc_fetch_check.sv
verilog/if_id_stage_reg.sv
verilog/cheri_fetch_top.sv
sim/cheri_fetch_properties.sv
sim/cheri_fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f cheri_fetch.f --top-module cheri_fetch_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/Vcheri_fetch_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Regression passed" "$LOG"; then
  exit 0
fi
exit 1
